// ==== flip_manager.f ====
+incdir+sim
hw/flip_pkg.sv
hw/spin_push_if.sv
hw/energy_fifo_maintainer.sv
hw/spin_fifo_maintainer.sv
hw/flip_engine.sv
hw/flip_manager.sv
sim/flip_manager_tb.sv

// ==== hw/energy_fifo_maintainer.sv ====
`timescale 1ns/1ps

module energy_fifo_maintainer #(
    parameter int NUM_SPIN         = flip_pkg::NUM_SPIN_DEF,
    parameter int SPIN_DEPTH       = flip_pkg::SPIN_DEPTH_DEF,
    parameter int ENERGY_TOTAL_BIT = flip_pkg::ENERGY_BIT_DEF
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               en_i,
    input  logic                               flush_i,
    input  logic                               en_comparison_i,

    input  logic                               energy_valid_i,
    input  logic signed [ENERGY_TOTAL_BIT-1:0] energy_i,
    input  logic        [NUM_SPIN-1:0]         spin_i,
    output logic                               energy_ready_o,

    spin_push_if.source                        push
);

    localparam int SLOT_BIT = (SPIN_DEPTH > 1) ? $clog2(SPIN_DEPTH) : 1;

    typedef logic signed [ENERGY_TOTAL_BIT-1:0] energy_val_t;
    typedef logic [SLOT_BIT-1:0] slot_idx_t;
    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    localparam energy_val_t ENERGY_MAX = {1'b0, {(ENERGY_TOTAL_BIT-1){1'b1}}};
    localparam slot_idx_t LAST_SLOT = slot_idx_t'(SPIN_DEPTH - 1);

    // Best energy seen so far for each FIFO slot
    energy_val_t best_q [SPIN_DEPTH];
    slot_idx_t   slot_q;

    logic        push_valid_q;
    spin_vec_t   push_spin_q;
    logic        push_none_q;

    logic        accept;
    logic        take_new;

    // Only take an energy when its push can go out right behind it
    assign energy_ready_o = en_i & push.ready;
    assign accept = energy_valid_i & energy_ready_o;

    // Lower energy wins, without comparison the newest spin always wins
    assign take_new = !en_comparison_i || (energy_i < best_q[slot_q]);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            push_valid_q <= 1'b0;
            slot_q <= '0;
            for (int i = 0; i < SPIN_DEPTH; i++) begin
                best_q[i] <= ENERGY_MAX;
            end
        end else if (flush_i) begin
            push_valid_q <= 1'b0;
            slot_q <= '0;
            for (int i = 0; i < SPIN_DEPTH; i++) begin
                best_q[i] <= ENERGY_MAX;
            end
        end else begin
            if (accept) begin
                push_valid_q <= 1'b1;
                // Slots come back in the order they were popped
                slot_q <= (slot_q == LAST_SLOT) ? '0 : slot_q + 1'b1;
                if (take_new) begin
                    best_q[slot_q] <= energy_i;
                end
            end else if (push.ready) begin
                push_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            push_spin_q <= spin_i;
            push_none_q <= !take_new;
        end
    end

    assign push.valid     = push_valid_q;
    assign push.spin      = push_spin_q;
    assign push.push_none = push_none_q;

    // A pending push keeps its payload until the spin FIFO takes it
    a_push_hold : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        push.valid && !push.ready |=>
            push.valid && $stable(push.spin) && $stable(push.push_none)
    );

endmodule

// ==== hw/flip_engine.sv ====
`timescale 1ns/1ps

module flip_engine #(
    parameter int NUM_SPIN        = flip_pkg::NUM_SPIN_DEF,
    parameter int FLIP_ICON_DEPTH = flip_pkg::ICON_DEPTH_DEF,
    localparam int ICON_ADDR_BIT  = $clog2(FLIP_ICON_DEPTH) + 1
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cmpt_en_i,
    input  logic                     flush_i,
    input  logic                     flip_disable_i,

    input  logic                     prev_spin_valid_i,
    input  logic [NUM_SPIN-1:0]      prev_spin_i,
    output logic                     prev_spin_ready_o,

    output logic                     flipped_spin_valid_o,
    output logic [NUM_SPIN-1:0]      flipped_spin_o,
    input  logic                     flipped_spin_ready_i,

    output logic                     flip_ren_o,
    output logic [ICON_ADDR_BIT-1:0] flip_raddr_o,
    input  logic [NUM_SPIN-1:0]      flip_rdata_i,
    input  logic [ICON_ADDR_BIT-1:0] icon_last_raddr_plus_one_i,
    output logic                     icon_finish_o
);

    typedef logic [NUM_SPIN-1:0] spin_vec_t;
    typedef logic [ICON_ADDR_BIT-1:0] icon_addr_vec_t;

    // High from computation start until the icon range runs out
    logic           active_q;
    icon_addr_vec_t raddr_q;
    icon_addr_vec_t raddr_inc;
    logic           last_icon;

    logic           s1_valid_q;
    logic           s1_fresh_q;
    logic           s1_flip_q;
    spin_vec_t      s1_spin_q;
    spin_vec_t      s1_data;
    logic           out_valid_q;
    spin_vec_t      out_spin_q;

    logic           s1_move;
    logic           accept;

    assign s1_move = s1_valid_q & (~out_valid_q | flipped_spin_ready_i);
    assign prev_spin_ready_o = ~s1_valid_q | s1_move;
    assign accept = prev_spin_valid_i & prev_spin_ready_o;

    assign raddr_inc = raddr_q + 1'b1;
    assign last_icon = (raddr_inc == icon_last_raddr_plus_one_i);
    assign flip_ren_o = accept & active_q;
    assign flip_raddr_o = raddr_q;
    assign icon_finish_o = flip_ren_o & last_icon;

    // Icon data sits on the bus only in the cycle after the read
    assign s1_data = (s1_fresh_q && s1_flip_q) ? (s1_spin_q ^ flip_rdata_i) : s1_spin_q;

    assign flipped_spin_valid_o = out_valid_q;
    assign flipped_spin_o = out_spin_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            raddr_q <= '0;
            s1_valid_q <= 1'b0;
            s1_fresh_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            active_q <= 1'b0;
            raddr_q <= '0;
            s1_valid_q <= 1'b0;
            s1_fresh_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (icon_finish_o) begin
                active_q <= 1'b0;
            end else if (cmpt_en_i) begin
                active_q <= 1'b1;
            end
            if (flip_ren_o) begin
                raddr_q <= last_icon ? '0 : raddr_inc;
            end
            if (accept) begin
                s1_valid_q <= 1'b1;
            end else if (s1_move) begin
                s1_valid_q <= 1'b0;
            end
            s1_fresh_q <= accept;
            if (s1_move) begin
                out_valid_q <= 1'b1;
            end else if (flipped_spin_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            s1_spin_q <= prev_spin_i;
            // Disabled flips still consume an icon address
            s1_flip_q <= active_q & ~flip_disable_i;
        end else if (s1_fresh_q) begin
            // Stalled, so fold the icon in before it is gone
            s1_spin_q <= s1_data;
        end
        if (s1_move) begin
            out_spin_q <= s1_data;
        end
    end

    a_raddr_in_range : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        active_q |-> flip_raddr_o < icon_last_raddr_plus_one_i
    );

endmodule

// ==== hw/flip_manager.sv ====
`timescale 1ns/1ps

module flip_manager #(
    parameter int NUM_SPIN         = flip_pkg::NUM_SPIN_DEF,
    parameter int SPIN_DEPTH       = flip_pkg::SPIN_DEPTH_DEF,
    parameter int ENERGY_TOTAL_BIT = flip_pkg::ENERGY_BIT_DEF,
    parameter int FLIP_ICON_DEPTH  = flip_pkg::ICON_DEPTH_DEF,
    localparam int ICON_ADDR_BIT   = $clog2(FLIP_ICON_DEPTH) + 1
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                en_i,
    input  logic                                flush_i,
    input  logic                                en_comparison_i,
    input  logic                                cmpt_en_i,
    input  logic                                host_readout_i,
    input  logic                                flip_disable_i,
    output logic                                cmpt_idle_o,

    input  logic                                spin_configure_valid_i,
    input  logic                                spin_configure_push_none_i,
    input  logic [NUM_SPIN-1:0]                 spin_configure_i,
    output logic                                spin_configure_ready_o,

    output logic                                spin_pop_valid_o,
    output logic [NUM_SPIN-1:0]                 spin_pop_o,
    input  logic                                spin_pop_ready_i,

    input  logic                                energy_valid_i,
    input  logic signed [ENERGY_TOTAL_BIT-1:0]  energy_i,
    input  logic [NUM_SPIN-1:0]                 spin_i,
    output logic                                energy_ready_o,

    output logic                                flip_ren_o,
    output logic [ICON_ADDR_BIT-1:0]            flip_raddr_o,
    input  logic [ICON_ADDR_BIT-1:0]            icon_last_raddr_plus_one_i,
    input  logic [NUM_SPIN-1:0]                 flip_rdata_i,

    output logic                                energy_fifo_update_o,
    output logic                                spin_fifo_update_o,
    output logic [SPIN_DEPTH-1:0][NUM_SPIN-1:0] spin_fifo_o
);

    logic                cmpt_busy;
    logic                icon_finish;
    logic                prev_spin_valid;
    logic [NUM_SPIN-1:0] prev_spin;
    logic                prev_spin_ready;

    spin_push_if #(.NUM_SPIN(NUM_SPIN)) energy_push ();
    spin_push_if #(.NUM_SPIN(NUM_SPIN)) fifo_push ();

    // Host loads the FIFO while idle, returned spins own it while busy
    assign fifo_push.valid     = cmpt_busy ? energy_push.valid : spin_configure_valid_i;
    assign fifo_push.spin      = cmpt_busy ? energy_push.spin : spin_configure_i;
    assign fifo_push.push_none = cmpt_busy ? energy_push.push_none : spin_configure_push_none_i;
    assign energy_push.ready   = fifo_push.ready & cmpt_busy;
    assign spin_configure_ready_o = fifo_push.ready & ~cmpt_busy;

    assign cmpt_idle_o = ~cmpt_busy;
    assign energy_fifo_update_o = energy_valid_i & energy_ready_o;
    assign spin_fifo_update_o = fifo_push.valid & fifo_push.ready;

    energy_fifo_maintainer #(
        .NUM_SPIN        (NUM_SPIN),
        .SPIN_DEPTH      (SPIN_DEPTH),
        .ENERGY_TOTAL_BIT(ENERGY_TOTAL_BIT)
    ) u_energy_fifo_maintainer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .en_i           (en_i),
        .flush_i        (flush_i),
        .en_comparison_i(en_comparison_i),
        .energy_valid_i (energy_valid_i),
        .energy_i       (energy_i),
        .spin_i         (spin_i),
        .energy_ready_o (energy_ready_o),
        .push           (energy_push)
    );

    spin_fifo_maintainer #(
        .NUM_SPIN  (NUM_SPIN),
        .SPIN_DEPTH(SPIN_DEPTH)
    ) u_spin_fifo_maintainer (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .en_i            (en_i),
        .flush_i         (flush_i),
        .cmpt_en_i       (cmpt_en_i),
        .icon_finish_i   (icon_finish),
        .host_readout_i  (host_readout_i),
        .push            (fifo_push),
        .spin_pop_valid_o(prev_spin_valid),
        .spin_pop_o      (prev_spin),
        .spin_pop_ready_i(prev_spin_ready),
        .cmpt_busy_o     (cmpt_busy),
        .spin_fifo_o     (spin_fifo_o)
    );

    flip_engine #(
        .NUM_SPIN       (NUM_SPIN),
        .FLIP_ICON_DEPTH(FLIP_ICON_DEPTH)
    ) u_flip_engine (
        .clk_i                     (clk_i),
        .rst_n_i                   (rst_n_i),
        .cmpt_en_i                 (cmpt_en_i),
        .flush_i                   (flush_i),
        .flip_disable_i            (flip_disable_i),
        .prev_spin_valid_i         (prev_spin_valid),
        .prev_spin_i               (prev_spin),
        .prev_spin_ready_o         (prev_spin_ready),
        .flipped_spin_valid_o      (spin_pop_valid_o),
        .flipped_spin_o            (spin_pop_o),
        .flipped_spin_ready_i      (spin_pop_ready_i),
        .flip_ren_o                (flip_ren_o),
        .flip_raddr_o              (flip_raddr_o),
        .flip_rdata_i              (flip_rdata_i),
        .icon_last_raddr_plus_one_i(icon_last_raddr_plus_one_i),
        .icon_finish_o             (icon_finish)
    );

endmodule

// ==== hw/flip_pkg.sv ====
package flip_pkg;

    // Default core dimensions
    localparam int NUM_SPIN_DEF = 16;
    localparam int SPIN_DEPTH_DEF = 2;
    localparam int ENERGY_BIT_DEF = 16;
    localparam int ICON_DEPTH_DEF = 16;

    // One extra bit so the address one past the last icon fits
    localparam int ICON_ADDR_BIT_DEF = $clog2(ICON_DEPTH_DEF) + 1;
    localparam int SLOT_BIT_DEF = (SPIN_DEPTH_DEF > 1) ? $clog2(SPIN_DEPTH_DEF) : 1;

    // One bit per spin
    typedef logic [NUM_SPIN_DEF-1:0] spin_t;

    // Total Hamiltonian energy where lower is better
    typedef logic signed [ENERGY_BIT_DEF-1:0] energy_t;

    typedef logic [ICON_ADDR_BIT_DEF-1:0] icon_addr_t;

    // Spin FIFO slot index
    typedef logic [SLOT_BIT_DEF-1:0] slot_t;

endpackage

// ==== hw/spin_fifo_maintainer.sv ====
`timescale 1ns/1ps

module spin_fifo_maintainer #(
    parameter int NUM_SPIN   = flip_pkg::NUM_SPIN_DEF,
    parameter int SPIN_DEPTH = flip_pkg::SPIN_DEPTH_DEF
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                en_i,
    input  logic                                flush_i,
    input  logic                                cmpt_en_i,
    input  logic                                icon_finish_i,
    input  logic                                host_readout_i,

    spin_push_if.sink                           push,

    output logic                                spin_pop_valid_o,
    output logic [NUM_SPIN-1:0]                 spin_pop_o,
    input  logic                                spin_pop_ready_i,

    output logic                                cmpt_busy_o,
    output logic [SPIN_DEPTH-1:0][NUM_SPIN-1:0] spin_fifo_o
);

    localparam int SLOT_BIT = (SPIN_DEPTH > 1) ? $clog2(SPIN_DEPTH) : 1;
    localparam int CNT_BIT = $clog2(SPIN_DEPTH + 1);

    typedef logic [NUM_SPIN-1:0] spin_vec_t;
    typedef logic [SLOT_BIT-1:0] slot_idx_t;
    typedef logic [CNT_BIT-1:0] fill_cnt_t;
    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN} state_t;

    localparam slot_idx_t LAST_SLOT = slot_idx_t'(SPIN_DEPTH - 1);
    localparam fill_cnt_t FULL = fill_cnt_t'(SPIN_DEPTH);

    spin_vec_t mem [SPIN_DEPTH];
    slot_idx_t rd_ptr_q;
    slot_idx_t wr_ptr_q;
    fill_cnt_t cnt_q;
    fill_cnt_t cnt_d;
    logic      ready_q;
    state_t    state_q;
    state_t    state_d;
    logic      push_hs;
    logic      pop_hs;

    assign push.ready = ready_q;
    assign push_hs = push.valid & ready_q;
    assign pop_hs = spin_pop_valid_o & spin_pop_ready_i;

    // No pops while draining, so every spin in flight can find its way home
    assign spin_pop_valid_o = en_i && (cnt_q != '0) &&
        ((state_q == ST_RUN) || (state_q == ST_IDLE && host_readout_i));
    assign spin_pop_o = mem[rd_ptr_q];
    assign cmpt_busy_o = (state_q != ST_IDLE);

    always_comb begin
        cnt_d = cnt_q;
        if (push_hs && !pop_hs) begin
            cnt_d = cnt_q + 1'b1;
        end else if (pop_hs && !push_hs) begin
            cnt_d = cnt_q - 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (cmpt_en_i && cnt_q == FULL) state_d = ST_RUN;
            ST_RUN:   if (icon_finish_i) state_d = ST_DRAIN;
            ST_DRAIN: if (cnt_q == FULL) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            ready_q <= 1'b0;
        end else if (flush_i) begin
            state_q <= ST_IDLE;
            cnt_q <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q <= cnt_d;
            // Registered ready looks at next cycle's fill level
            ready_q <= en_i && (cnt_d != FULL);
            if (pop_hs) begin
                rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_hs) begin
                wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
            end
        end
    end

    // Popped slot is not reused until its own result comes back,
    // so push_none just leaves the old spin where it is
    always_ff @(posedge clk_i) begin
        if (push_hs && !push.push_none) begin
            mem[wr_ptr_q] <= push.spin;
        end
    end

    // Contents listed oldest first
    always_comb begin
        logic [SLOT_BIT:0] idx;
        for (int i = 0; i < SPIN_DEPTH; i++) begin
            idx = {1'b0, rd_ptr_q} + (SLOT_BIT + 1)'(i);
            if (idx >= (SLOT_BIT + 1)'(SPIN_DEPTH)) begin
                idx = idx - (SLOT_BIT + 1)'(SPIN_DEPTH);
            end
            spin_fifo_o[i] = mem[slot_idx_t'(idx)];
        end
    end

    a_no_push_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        push_hs |-> (cnt_q != FULL) || pop_hs
    );

    // Pointers must still show stored data whenever a spin leaves
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        pop_hs |-> (rd_ptr_q != wr_ptr_q) || (cnt_q == FULL)
    );

endmodule

// ==== hw/spin_push_if.sv ====
`timescale 1ns/1ps

interface spin_push_if #(
    parameter int NUM_SPIN = flip_pkg::NUM_SPIN_DEF
);

    logic                valid;
    logic [NUM_SPIN-1:0] spin;
    // Keep the slot's previous occupant instead of spin
    logic                push_none;
    logic                ready;

    modport source (
        output valid,
        output spin,
        output push_none,
        input  ready
    );

    modport sink (
        input  valid,
        input  spin,
        input  push_none,
        output ready
    );

endinterface

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module flip_manager_tb \
    -f flip_manager.f -o sim_flip_manager

if ./obj_dir/sim_flip_manager | tee /dev/stderr | grep -q "ALL CHECKS PASSED"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== sim/flip_model.svh ====
`ifndef FLIP_MODEL_SVH
`define FLIP_MODEL_SVH

// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_q = 16'd6;

flip_pkg::spin_t   icon_mem [flip_pkg::ICON_DEPTH_DEF];
flip_pkg::energy_t best_e [flip_pkg::SPIN_DEPTH_DEF];
flip_pkg::slot_t   slot_n;

// Kept spins oldest first, popped originals, expected pops, spins owed an energy
flip_pkg::spin_t model_fifo [$];
flip_pkg::spin_t orig_q [$];
flip_pkg::spin_t exp_pop [$];
flip_pkg::spin_t ret_q [$];

function automatic logic lfsr_step();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    return lfsr_q[0];
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_step()};
    end
    return r;
endfunction

// Weighted popcount stands in for the Hamiltonian
function automatic flip_pkg::energy_t energy_of(flip_pkg::spin_t s);
    int e;
    e = 0;
    for (int i = 0; i < flip_pkg::NUM_SPIN_DEF; i++) begin
        if (s[i]) e += i * 5 - 37;
    end
    return flip_pkg::energy_t'(e);
endfunction

task automatic model_reset();
    for (int i = 0; i < flip_pkg::SPIN_DEPTH_DEF; i++) begin
        best_e[i] = 16'sh7fff;
    end
    slot_n = '0;
    model_fifo.delete();
    orig_q.delete();
    exp_pop.delete();
    ret_q.delete();
endtask

// Lower energy wins the slot and a loser leaves the popped spin in place
task automatic model_return(flip_pkg::spin_t s, flip_pkg::energy_t e, logic cmp);
    flip_pkg::spin_t orig;
    orig = orig_q.pop_front();
    if (!cmp || e < best_e[slot_n]) begin
        best_e[slot_n] = e;
        model_fifo.push_back(s);
    end else begin
        model_fifo.push_back(orig);
    end
    slot_n = flip_pkg::slot_t'((int'(slot_n) + 1) % flip_pkg::SPIN_DEPTH_DEF);
endtask

`endif

// ==== sim/flip_manager_tb.sv ====
`timescale 1ns/1ps

module flip_manager_tb;

    localparam int DEPTH = flip_pkg::SPIN_DEPTH_DEF;
    // Sum of the icon limits of all computations sets the watchdog budget
    localparam int ICON_SUM = 11 + 6 + 12 + 5;
    localparam int BUDGET_CYCLES = ICON_SUM * 40 + 600;

    logic clk_i = 1'b0;
    logic rst_n_i = 1'b0;
    logic en_i = 1'b0, flush_i = 1'b0, en_comparison_i = 1'b0, cmpt_en_i = 1'b0;
    logic host_readout_i = 1'b0, flip_disable_i = 1'b0, cmpt_idle_o;
    logic spin_configure_valid_i = 1'b0, spin_configure_push_none_i = 1'b0;
    flip_pkg::spin_t spin_configure_i = '0;
    logic spin_configure_ready_o, spin_pop_valid_o, spin_pop_ready_i = 1'b0;
    flip_pkg::spin_t spin_pop_o;
    logic energy_valid_i = 1'b0, energy_ready_o, flip_ren_o;
    flip_pkg::energy_t energy_i = '0;
    flip_pkg::spin_t spin_i = '0, flip_rdata_i = '0, ret_spin, popped;
    flip_pkg::icon_addr_t flip_raddr_o, icon_last_raddr_plus_one_i = '0, icon_addr_l = '0;
    logic energy_fifo_update_o, spin_fifo_update_o;
    logic [DEPTH-1:0][flip_pkg::NUM_SPIN_DEF-1:0] spin_fifo_o;

    logic running = 1'b0;
    logic energy_taken = 1'b0;
    int   exp_addr = 0;

    `include "flip_model.svh"

    flip_manager dut (.*);

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check(string name, logic [63:0] exp, logic [63:0] act);
        assert (exp === act)
            else fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    // Icon memory, spin consumer and energy calculator
    always @(posedge clk_i) begin
        spin_pop_ready_i <= (rand_bits(2) != 0);
        flip_rdata_i <= icon_mem[icon_addr_l];
        if (!running) begin
            energy_valid_i <= 1'b0;
        end else if (!energy_valid_i || energy_taken) begin
            if (ret_q.size() > 0) begin
                ret_spin = ret_q.pop_front();
                energy_valid_i <= 1'b1;
                spin_i <= ret_spin;
                energy_i <= energy_of(ret_spin);
            end else begin
                energy_valid_i <= 1'b0;
            end
        end
    end

    always @(negedge clk_i) begin
        energy_taken = energy_valid_i && energy_ready_o;
        if (running && !flush_i) begin
            check("energy_update", energy_taken, energy_fifo_update_o);
            if (host_readout_i) check("readout_ren", 0, flip_ren_o);
            if (flip_ren_o) begin
                assert (model_fifo.size() > 0)
                    else fail_run("Icon read with the FIFO model empty");
                check("icon_addr", exp_addr, flip_raddr_o);
                popped = model_fifo.pop_front();
                orig_q.push_back(popped);
                exp_pop.push_back(flip_disable_i ? popped : popped ^ icon_mem[flip_raddr_o]);
                icon_addr_l = flip_raddr_o;
                exp_addr = (exp_addr + 1 == int'(icon_last_raddr_plus_one_i)) ?
                    0 : exp_addr + 1;
            end
            if (spin_pop_valid_o && spin_pop_ready_i) begin
                if (host_readout_i) begin
                    assert (model_fifo.size() > 0)
                        else fail_run("Readout popped too many spins");
                    check("readout", model_fifo.pop_front(), spin_pop_o);
                end else begin
                    assert (exp_pop.size() > 0)
                        else fail_run("Spin popped with none expected");
                    check("flip", exp_pop.pop_front(), spin_pop_o);
                    ret_q.push_back(spin_pop_o);
                end
            end
            if (energy_taken) model_return(spin_i, energy_i, en_comparison_i);
        end
    end

    task automatic load_fifo();
        flip_pkg::spin_t s;
        for (int i = 0; i < DEPTH; i++) begin
            @(negedge clk_i);
            s = rand_bits(flip_pkg::NUM_SPIN_DEF);
            @(posedge clk_i);
            spin_configure_valid_i <= 1'b1;
            spin_configure_i <= s;
            do @(negedge clk_i); while (!spin_configure_ready_o);
            check("load_update", 1, spin_fifo_update_o);
            model_fifo.push_back(s);
            @(posedge clk_i);
            spin_configure_valid_i <= 1'b0;
            @(negedge clk_i);
            check("load", s, spin_fifo_o[i]);
        end
        check("full_ready", 0, spin_configure_ready_o);
    endtask

    task automatic start_cmpt(int limit, logic cmp, logic dis);
        @(posedge clk_i);
        icon_last_raddr_plus_one_i <= flip_pkg::icon_addr_t'(limit);
        en_comparison_i <= cmp;
        flip_disable_i <= dis;
        cmpt_en_i <= 1'b1;
        @(posedge clk_i);
        cmpt_en_i <= 1'b0;
        @(negedge clk_i);
        check("busy", 0, cmpt_idle_o);
    endtask

    task automatic finish_cmpt();
        do @(negedge clk_i); while (!cmpt_idle_o);
        check("in_flight", 0, exp_pop.size() + ret_q.size());
        check("next_addr", 0, flip_raddr_o);
        for (int i = 0; i < DEPTH; i++) begin
            check("select", model_fifo[i], spin_fifo_o[i]);
        end
    endtask

    task automatic readout_all();
        @(posedge clk_i);
        host_readout_i <= 1'b1;
        do @(posedge clk_i); while (model_fifo.size() > 0);
        host_readout_i <= 1'b0;
    endtask

    task automatic flush_core();
        @(negedge clk_i);
        running = 1'b0;
        model_reset();
        exp_addr = 0;
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
        check("flush_idle", 1, cmpt_idle_o);
        check("flush_pop", 0, spin_pop_valid_o);
        check("flush_energy_ready", 0, energy_ready_o);
        @(negedge clk_i);
        check("flush_empty", 1, spin_configure_ready_o);
        running = 1'b1;
    endtask

    initial begin
        #(BUDGET_CYCLES * 40);
        $display("Timeout, the tests did not finish within the cycle budget");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        for (int i = 0; i < flip_pkg::ICON_DEPTH_DEF; i++) begin
            icon_mem[i] = rand_bits(flip_pkg::NUM_SPIN_DEF);
        end
        model_reset();
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        en_i <= 1'b1;
        running = 1'b1;
        load_fifo();
        start_cmpt(11, 1'b1, 1'b0);
        finish_cmpt();
        readout_all();
        // Flips disabled and the newest spin always kept
        load_fifo();
        start_cmpt(6, 1'b0, 1'b1);
        finish_cmpt();
        readout_all();
        // Flush in the middle of a computation
        load_fifo();
        start_cmpt(12, 1'b1, 1'b0);
        do @(posedge clk_i); while (exp_addr < 4);
        flush_core();
        load_fifo();
        start_cmpt(5, 1'b1, 1'b0);
        finish_cmpt();
        readout_all();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
